// File: design/exec_settings.svh
// Execute stage settings
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Data path width and reset vector
`define EXEC_XLEN 32
`define EXEC_RESET_PC 32'h8000_0000

// Machine register write addresses, above the 32 general registers
`define EXEC_CSR_MEPC 6'h21
`define EXEC_CSR_MTVAL 6'h22
`define EXEC_CSR_MCAUSE 6'h23

// Trap cause codes
`define EXEC_CAUSE_LD_MISALIGN 4'd4
`define EXEC_CAUSE_ST_MISALIGN 4'd6
`define EXEC_CAUSE_EBREAK 4'd3
`define EXEC_CAUSE_ECALL 4'd11

`endif

// File: design/exec_pkg.sv
// Execute stage types
package exec_pkg;

	// Instruction class from the decoder
	typedef enum logic [2:0] {
		op_arith  = 3'd0,
		op_branch = 3'd1,
		op_jump   = 3'd2,
		op_ldst   = 3'd3,
		op_mds    = 3'd4,
		op_system = 3'd5
	} op_type_e;

	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_and    = 4'd2,
		alu_or     = 4'd3,
		alu_xor    = 4'd4,
		alu_slt    = 4'd5,
		alu_sltu   = 4'd6,
		alu_eq     = 4'd7,
		alu_ne     = 4'd8,
		alu_lt     = 4'd9,
		alu_ge     = 4'd10,
		alu_pass_a = 4'd11,
		alu_pass_b = 4'd12
	} alu_op_e;

	// Bit 3 marks a store, bit 2 an unsigned load, bits 1:0 the size
	typedef enum logic [3:0] {
		mem_lb  = 4'b0000,
		mem_lh  = 4'b0001,
		mem_lw  = 4'b0010,
		mem_lbu = 4'b0100,
		mem_lhu = 4'b0101,
		mem_sb  = 4'b1000,
		mem_sh  = 4'b1001,
		mem_sw  = 4'b1010
	} mem_op_e;

	typedef enum logic [1:0] {
		mds_sll = 2'd0,
		mds_srl = 2'd1,
		mds_sra = 2'd2,
		mds_mul = 2'd3
	} mds_op_e;

	typedef enum logic [1:0] {
		sys_ecall  = 2'd0,
		sys_ebreak = 2'd1,
		sys_eret   = 2'd2
	} sys_op_e;

	typedef enum logic [3:0] {
		st_execute      = 4'd0,
		st_branch_taken = 4'd1,
		st_jump         = 4'd2,
		st_mds_wait     = 4'd3,
		st_ldst_wait    = 4'd4,
		st_exc_epc      = 4'd5,
		st_exc_tval     = 4'd6,
		st_exc_cause    = 4'd7
	} exec_state_e;

endpackage

// File: design/lsu_if.sv
// Core to load-store unit link
`timescale 1ns/1ns
`include "exec_settings.svh"

interface lsu_if import exec_pkg::*; ();
	// One-cycle request from the core
	logic                  req_valid;
	logic [`EXEC_XLEN-1:0] req_addr;
	mem_op_e               req_op;
	logic [`EXEC_XLEN-1:0] req_data;

	// One-cycle completion, load data already extended
	logic                  ack_valid;
	logic [`EXEC_XLEN-1:0] ack_data;

	modport core (output req_valid, req_addr, req_op, req_data,
		input ack_valid, ack_data);

	modport lsu (input req_valid, req_addr, req_op, req_data,
		output ack_valid, ack_data);
endinterface

// File: design/exec_alu.sv
// Single-cycle ALU
`timescale 1ns/1ns
`include "exec_settings.svh"

module exec_alu import exec_pkg::*; (
	input  logic [`EXEC_XLEN-1:0] a,
	input  logic [`EXEC_XLEN-1:0] b,
	input  alu_op_e               op,
	output logic [`EXEC_XLEN-1:0] result
);

	logic lt_s;
	logic lt_u;
	logic eq;

	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;
	assign eq = (a == b);

	// Compare results land in bit 0
	always_comb begin
		case (op)
			alu_add:    result = a + b;
			alu_sub:    result = a - b;
			alu_and:    result = a & b;
			alu_or:     result = a | b;
			alu_xor:    result = a ^ b;
			alu_slt:    result = {{(`EXEC_XLEN-1){1'b0}}, lt_s};
			alu_lt:     result = {{(`EXEC_XLEN-1){1'b0}}, lt_s};
			alu_ge:     result = {{(`EXEC_XLEN-1){1'b0}}, !lt_s};
			alu_sltu:   result = {{(`EXEC_XLEN-1){1'b0}}, lt_u};
			alu_eq:     result = {{(`EXEC_XLEN-1){1'b0}}, eq};
			alu_ne:     result = {{(`EXEC_XLEN-1){1'b0}}, !eq};
			alu_pass_a: result = a;
			alu_pass_b: result = b;
			default:    result = '0;
		endcase
	end

endmodule

// File: design/exec_mds.sv
// Iterative shift and multiply unit
`timescale 1ns/1ns
`include "exec_settings.svh"

module exec_mds import exec_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic [`EXEC_XLEN-1:0] in_a,
	input  logic [`EXEC_XLEN-1:0] in_b,
	input  mds_op_e               op,
	input  logic                  in_valid,
	output logic [`EXEC_XLEN-1:0] out,
	output logic                  out_valid
);

	logic                  busy;
	logic [4:0]            count;
	mds_op_e               op_r;
	logic [`EXEC_XLEN-1:0] val;
	logic [`EXEC_XLEN-1:0] amt;
	logic [`EXEC_XLEN-1:0] acc;

	// Fixed 32-step sequence regardless of shift amount
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			if (in_valid) begin
				busy <= 1'b1;
				count <= '0;
			end else if (busy) begin
				count <= count + 5'd1;
				if (count == 5'd31) begin
					busy <= 1'b0;
					out_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid) begin
			op_r <= op;
			val <= in_a;
			acc <= '0;
			amt <= (op == mds_mul) ? in_b : {{(`EXEC_XLEN-5){1'b0}}, in_b[4:0]};
		end else if (busy) begin
			if (op_r == mds_mul) begin
				// Shift-and-add, one multiplier bit per step
				if (amt[0])
					acc <= acc + val;
				val <= val << 1;
				amt <= amt >> 1;
			end else if (amt != '0) begin
				amt <= amt - 1'b1;
				case (op_r)
					mds_sll: val <= val << 1;
					mds_srl: val <= val >> 1;
					default: val <= {val[`EXEC_XLEN-1], val[`EXEC_XLEN-1:1]};
				endcase
			end
		end
	end

	assign out = (op_r == mds_mul) ? acc : val;

endmodule

// File: design/exec_lsu.sv
// Load-store unit
`timescale 1ns/1ns
`include "exec_settings.svh"

module exec_lsu import exec_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	lsu_if.lsu                    lsu,
	output logic                  dvalid,
	output logic                  dwrite,
	output logic [`EXEC_XLEN-1:0] daddr,
	output logic [`EXEC_XLEN-1:0] dwdata,
	output logic [3:0]            dwstb,
	input  logic [`EXEC_XLEN-1:0] drdata,
	input  logic                  dready
);

	mem_op_e               op_r;
	logic [1:0]            addr_lo;
	logic [`EXEC_XLEN-1:0] st_data;
	logic [3:0]            st_stb;
	logic [`EXEC_XLEN-1:0] lane_data;
	logic [`EXEC_XLEN-1:0] ld_data;

	// Replicate store data across lanes, strobe picks the bytes
	always_comb begin
		case (lsu.req_op)
			mem_sb, mem_lb, mem_lbu: begin
				st_data = {4{lsu.req_data[7:0]}};
				st_stb = 4'b0001 << lsu.req_addr[1:0];
			end
			mem_sh, mem_lh, mem_lhu: begin
				st_data = {2{lsu.req_data[15:0]}};
				st_stb = lsu.req_addr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				st_data = lsu.req_data;
				st_stb = 4'b1111;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			dvalid <= 1'b0;
			lsu.ack_valid <= 1'b0;
		end else begin
			lsu.ack_valid <= 1'b0;
			if (lsu.req_valid) begin
				dvalid <= 1'b1;
			end else if (dvalid && dready) begin
				dvalid <= 1'b0;
				lsu.ack_valid <= 1'b1;
			end
		end
	end

	// Bus fields only change on a new request, so they hold until dready
	always_ff @(posedge clock) begin
		if (lsu.req_valid) begin
			daddr <= {lsu.req_addr[`EXEC_XLEN-1:2], 2'b00};
			dwrite <= lsu.req_op inside {mem_sb, mem_sh, mem_sw};
			dwdata <= st_data;
			dwstb <= st_stb;
			op_r <= lsu.req_op;
			addr_lo <= lsu.req_addr[1:0];
		end
		if (dvalid && dready)
			lsu.ack_data <= ld_data;
	end

	// Bring the addressed byte or half-word down to bit 0
	assign lane_data = drdata >> {addr_lo, 3'b000};

	always_comb begin
		case (op_r)
			mem_lb:  ld_data = {{(`EXEC_XLEN-8){lane_data[7]}}, lane_data[7:0]};
			mem_lbu: ld_data = {{(`EXEC_XLEN-8){1'b0}}, lane_data[7:0]};
			mem_lh:  ld_data = {{(`EXEC_XLEN-16){lane_data[15]}}, lane_data[15:0]};
			mem_lhu: ld_data = {{(`EXEC_XLEN-16){1'b0}}, lane_data[15:0]};
			default: ld_data = drdata;
		endcase
	end

endmodule

// File: design/exec_core.sv
// Execute stage control
`timescale 1ns/1ns
`include "exec_settings.svh"

module exec_core import exec_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  decode_valid,
	input  logic                  instr_c,
	input  op_type_e              op_type,
	input  logic [3:0]            op,
	input  logic [`EXEC_XLEN-1:0] op_a,
	input  logic [`EXEC_XLEN-1:0] op_b,
	input  logic [`EXEC_XLEN-1:0] op_c,
	input  logic [5:0]            rd,
	input  logic [`EXEC_XLEN-1:0] mtvec,
	output logic                  instr_complete,
	output logic                  rd_wen,
	output logic [5:0]            rd_waddr,
	output logic [`EXEC_XLEN-1:0] rd_wdata,
	output logic [`EXEC_XLEN-1:0] pc,
	output logic                  pc_seq,
	output logic [`EXEC_XLEN-1:0] alu_a,
	output logic [`EXEC_XLEN-1:0] alu_b,
	output alu_op_e               alu_op,
	input  logic [`EXEC_XLEN-1:0] alu_out,
	output logic                  mds_valid,
	input  logic [`EXEC_XLEN-1:0] mds_out,
	input  logic                  mds_done,
	lsu_if.core                   lsu
);

	exec_state_e           state;
	mem_op_e               mem_op;
	sys_op_e               sys_op;
	logic                  go;
	logic                  is_store;
	logic                  misaligned;
	logic [`EXEC_XLEN-1:0] next_pc_seq;
	logic [`EXEC_XLEN-1:0] mtval;
	logic [3:0]            mcause;

	assign mem_op = mem_op_e'(op);
	assign sys_op = sys_op_e'(op[1:0]);
	assign is_store = mem_op inside {mem_sb, mem_sh, mem_sw};

	// Decoder keeps valid up during the complete cycle
	assign go = decode_valid && !instr_complete;
	assign next_pc_seq = pc + (instr_c ? 32'd2 : 32'd4);

	always_comb begin
		misaligned = 1'b0;
		if (state == st_execute && op_type == op_ldst) begin
			case (mem_op)
				mem_lh, mem_lhu, mem_sh: misaligned = alu_out[0];
				mem_lw, mem_sw:          misaligned = |alu_out[1:0];
				default:                 misaligned = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_execute;
			pc <= `EXEC_RESET_PC;
			pc_seq <= 1'b1;
			instr_complete <= 1'b0;
		end else begin
			instr_complete <= 1'b0;
			case (state)
				st_execute: begin
					if (go) begin
						case (op_type)
							op_branch: begin
								if (alu_out[0]) begin
									state <= st_branch_taken;
								end else begin
									pc <= next_pc_seq;
									pc_seq <= 1'b1;
									instr_complete <= 1'b1;
								end
							end
							op_jump: state <= st_jump;
							op_ldst: state <= misaligned ? st_exc_epc : st_ldst_wait;
							op_mds:  state <= st_mds_wait;
							op_system: begin
								if (sys_op == sys_eret) begin
									pc <= op_a;
									pc_seq <= 1'b0;
									instr_complete <= 1'b1;
								end else begin
									state <= st_exc_epc;
								end
							end
							default: begin
								pc <= next_pc_seq;
								pc_seq <= 1'b1;
								instr_complete <= 1'b1;
							end
						endcase
					end
				end
				st_branch_taken, st_jump: begin
					// Target bit 0 is zero for a taken branch
					pc <= {alu_out[`EXEC_XLEN-1:1], 1'b0};
					pc_seq <= 1'b0;
					instr_complete <= 1'b1;
					state <= st_execute;
				end
				st_mds_wait, st_ldst_wait: begin
					if ((state == st_mds_wait) ? mds_done : lsu.ack_valid) begin
						pc <= next_pc_seq;
						pc_seq <= 1'b1;
						instr_complete <= 1'b1;
						state <= st_execute;
					end
				end
				st_exc_epc: state <= st_exc_tval;
				st_exc_tval: state <= st_exc_cause;
				st_exc_cause: begin
					pc <= mtvec;
					pc_seq <= 1'b0;
					instr_complete <= 1'b1;
					state <= st_execute;
				end
				default: state <= st_execute;
			endcase
		end
	end

	// Trap details captured on entry to the exception sequence
	always_ff @(posedge clock) begin
		if (state == st_execute && go) begin
			if (misaligned) begin
				mtval <= alu_out;
				mcause <= is_store ? `EXEC_CAUSE_ST_MISALIGN : `EXEC_CAUSE_LD_MISALIGN;
			end else if (op_type == op_system) begin
				mtval <= '0;
				mcause <= (sys_op == sys_ebreak) ? `EXEC_CAUSE_EBREAK : `EXEC_CAUSE_ECALL;
			end
		end
	end

	// Operand and opcode selection
	always_comb begin
		alu_a = op_a;
		alu_b = op_b;
		alu_op = alu_op_e'(op);
		if (state == st_execute && op_type == op_jump) begin
			// Link value
			alu_a = next_pc_seq;
			alu_op = alu_pass_a;
		end else if (state == st_execute && op_type == op_ldst) begin
			alu_b = op_c;
			alu_op = alu_add;
		end else if (state == st_branch_taken || state == st_jump) begin
			alu_a = (state == st_branch_taken) ? pc : op_a;
			alu_b = op_c;
			alu_op = alu_add;
		end
	end

	assign mds_valid = go && state == st_execute && op_type == op_mds;

	assign lsu.req_valid = go && state == st_execute && op_type == op_ldst && !misaligned;
	assign lsu.req_addr = alu_out;
	assign lsu.req_op = mem_op;
	assign lsu.req_data = op_b;

	always_comb begin
		rd_wen = 1'b0;
		rd_waddr = rd;
		rd_wdata = alu_out;
		case (state)
			st_execute:   rd_wen = go && (op_type == op_arith || op_type == op_jump);
			st_mds_wait: begin
				rd_wen = go && mds_done;
				rd_wdata = mds_out;
			end
			st_ldst_wait: begin
				rd_wen = go && lsu.ack_valid && !is_store;
				rd_wdata = lsu.ack_data;
			end
			st_exc_epc: begin
				rd_wen = go;
				rd_waddr = `EXEC_CSR_MEPC;
				rd_wdata = pc;
			end
			st_exc_tval: begin
				rd_wen = go;
				rd_waddr = `EXEC_CSR_MTVAL;
				rd_wdata = mtval;
			end
			st_exc_cause: begin
				rd_wen = go;
				rd_waddr = `EXEC_CSR_MCAUSE;
				rd_wdata = {{(`EXEC_XLEN-4){1'b0}}, mcause};
			end
			default: rd_wen = 1'b0;
		endcase
	end

endmodule

// File: design/exec_unit.sv
// Execute stage top level
`timescale 1ns/1ns
`include "exec_settings.svh"

module exec_unit import exec_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  decode_valid,
	input  logic                  instr_c,
	input  op_type_e              op_type,
	input  logic [3:0]            op,
	input  logic [`EXEC_XLEN-1:0] op_a,
	input  logic [`EXEC_XLEN-1:0] op_b,
	input  logic [`EXEC_XLEN-1:0] op_c,
	input  logic [5:0]            rd,
	input  logic [`EXEC_XLEN-1:0] mtvec,
	output logic                  instr_complete,
	output logic                  rd_wen,
	output logic [5:0]            rd_waddr,
	output logic [`EXEC_XLEN-1:0] rd_wdata,
	output logic [`EXEC_XLEN-1:0] pc,
	output logic                  pc_seq,
	output logic                  dvalid,
	output logic                  dwrite,
	output logic [`EXEC_XLEN-1:0] daddr,
	output logic [`EXEC_XLEN-1:0] dwdata,
	output logic [3:0]            dwstb,
	input  logic [`EXEC_XLEN-1:0] drdata,
	input  logic                  dready
);

	logic [`EXEC_XLEN-1:0] alu_a;
	logic [`EXEC_XLEN-1:0] alu_b;
	alu_op_e               alu_op;
	logic [`EXEC_XLEN-1:0] alu_out;
	logic                  mds_valid;
	logic [`EXEC_XLEN-1:0] mds_out;
	logic                  mds_done;

	lsu_if lsu_bus ();

	exec_core u_core (
		.clock          (clock),
		.reset          (reset),
		.decode_valid   (decode_valid),
		.instr_c        (instr_c),
		.op_type        (op_type),
		.op             (op),
		.op_a           (op_a),
		.op_b           (op_b),
		.op_c           (op_c),
		.rd             (rd),
		.mtvec          (mtvec),
		.instr_complete (instr_complete),
		.rd_wen         (rd_wen),
		.rd_waddr       (rd_waddr),
		.rd_wdata       (rd_wdata),
		.pc             (pc),
		.pc_seq         (pc_seq),
		.alu_a          (alu_a),
		.alu_b          (alu_b),
		.alu_op         (alu_op),
		.alu_out        (alu_out),
		.mds_valid      (mds_valid),
		.mds_out        (mds_out),
		.mds_done       (mds_done),
		.lsu            (lsu_bus.core)
	);

	exec_alu u_alu (
		.a      (alu_a),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_out)
	);

	// Multiply and shift take their operands straight from the decoder
	exec_mds u_mds (
		.clock     (clock),
		.reset     (reset),
		.in_a      (op_a),
		.in_b      (op_b),
		.op        (mds_op_e'(op[1:0])),
		.in_valid  (mds_valid),
		.out       (mds_out),
		.out_valid (mds_done)
	);

	exec_lsu u_lsu (
		.clock  (clock),
		.reset  (reset),
		.lsu    (lsu_bus.lsu),
		.dvalid (dvalid),
		.dwrite (dwrite),
		.daddr  (daddr),
		.dwdata (dwdata),
		.dwstb  (dwstb),
		.drdata (drdata),
		.dready (dready)
	);

endmodule

// File: tb/exec_unit_sva.sv
// Execute stage assertions
`timescale 1ns/1ns
`include "exec_settings.svh"

module exec_unit_sva (
	input logic                  clock,
	input logic                  reset,
	input logic                  instr_complete,
	input logic                  rd_wen,
	input logic                  dvalid,
	input logic                  dready,
	input logic                  dwrite,
	input logic [`EXEC_XLEN-1:0] daddr,
	input logic [`EXEC_XLEN-1:0] dwdata,
	input logic [3:0]            dwstb
);

	// Read by the testbench after each cycle
	int unsigned fail_count = 0;

	// Completion is a one-cycle pulse
	complete_pulse: assert property (@(posedge clock) disable iff (reset)
		instr_complete |=> !instr_complete)
	else begin
		$error("instr_complete stayed high for a second cycle");
		fail_count++;
	end

	// Bus fields hold until the dready edge
	bus_hold: assert property (@(posedge clock) disable iff (reset)
		dvalid && !dready |=> dvalid && $stable(daddr) && $stable(dwrite)
			&& $stable(dwdata) && $stable(dwstb))
	else begin
		$error("data bus changed while waiting for dready");
		fail_count++;
	end

	write_gated: assert property (@(posedge clock) disable iff (reset)
		!(rd_wen && instr_complete))
	else begin
		$error("rd_wen high together with instr_complete");
		fail_count++;
	end

endmodule

// File: tb/exec_unit_tb.sv
// Execute stage testbench
`timescale 1ns/1ns
`include "exec_settings.svh"

module exec_unit_tb import exec_pkg::*; ();

	localparam int NUM_INSTR = 160;
	localparam int WATCH_CYCLES = (NUM_INSTR + 10) * 200;
	localparam logic [`EXEC_XLEN-1:0] LDST_BASE = 32'h0000_4000;

	logic                  clock;
	logic                  reset;
	logic                  decode_valid;
	logic                  instr_c;
	op_type_e              op_type;
	logic [3:0]            op;
	logic [`EXEC_XLEN-1:0] op_a;
	logic [`EXEC_XLEN-1:0] op_b;
	logic [`EXEC_XLEN-1:0] op_c;
	logic [5:0]            rd;
	logic [`EXEC_XLEN-1:0] mtvec;
	logic                  instr_complete;
	logic                  rd_wen;
	logic [5:0]            rd_waddr;
	logic [`EXEC_XLEN-1:0] rd_wdata;
	logic [`EXEC_XLEN-1:0] pc;
	logic                  pc_seq;
	logic                  dvalid;
	logic                  dwrite;
	logic [`EXEC_XLEN-1:0] daddr;
	logic [`EXEC_XLEN-1:0] dwdata;
	logic [3:0]            dwstb;
	logic [`EXEC_XLEN-1:0] drdata;
	logic                  dready;

	// Reference model state
	logic [`EXEC_XLEN-1:0] model_pc;
	logic                  model_seq;
	logic [5:0]            exp_waddr[$];
	logic [`EXEC_XLEN-1:0] exp_wdata[$];
	logic                  bus_expected;
	logic [`EXEC_XLEN-1:0] exp_daddr;
	logic                  exp_dwrite;
	logic [`EXEC_XLEN-1:0] exp_dwdata;
	logic [3:0]            exp_dwstb;
	logic [`EXEC_XLEN-1:0] shadow_mem [logic [`EXEC_XLEN-1:0]];

	exec_unit exec_unit_i (.*);

	bind exec_unit exec_unit_sva u_sva (
		.clock          (clock),
		.reset          (reset),
		.instr_complete (instr_complete),
		.rd_wen         (rd_wen),
		.dvalid         (dvalid),
		.dready         (dready),
		.dwrite         (dwrite),
		.daddr          (daddr),
		.dwdata         (dwdata),
		.dwstb          (dwstb)
	);

	always #50 clock = ~clock;

	task automatic abort_run();
		$display("Errors found");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_write(input logic [5:0] got_addr, input logic [`EXEC_XLEN-1:0] got_data,
			input logic [5:0] want_addr, input logic [`EXEC_XLEN-1:0] want_data);
		if (got_addr !== want_addr) begin
			$display("ERR rd_waddr: got %h, expected %h", got_addr, want_addr);
			abort_run();
		end
		if (got_data !== want_data) begin
			$display("ERR rd_wdata: got %h, expected %h", got_data, want_data);
			abort_run();
		end
	endtask

	task automatic check_pc(input logic [`EXEC_XLEN-1:0] got_pc, input logic got_seq,
			input logic [`EXEC_XLEN-1:0] want_pc, input logic want_seq);
		if (got_pc !== want_pc) begin
			$display("ERR pc: got %h, expected %h", got_pc, want_pc);
			abort_run();
		end
		if (got_seq !== want_seq) begin
			$display("ERR pc_seq: got %h, expected %h", got_seq, want_seq);
			abort_run();
		end
	endtask

	task automatic check_bus(input logic [`EXEC_XLEN-1:0] got_addr, input logic got_write,
			input logic [`EXEC_XLEN-1:0] got_data, input logic [3:0] got_stb,
			input logic [`EXEC_XLEN-1:0] want_addr, input logic want_write,
			input logic [`EXEC_XLEN-1:0] want_data, input logic [3:0] want_stb);
		logic [`EXEC_XLEN-1:0] mask;
		mask = {{8{want_stb[3]}}, {8{want_stb[2]}}, {8{want_stb[1]}}, {8{want_stb[0]}}};
		if (got_addr !== want_addr) begin
			$display("ERR daddr: got %h, expected %h", got_addr, want_addr);
			abort_run();
		end
		if (got_write !== want_write) begin
			$display("ERR dwrite: got %h, expected %h", got_write, want_write);
			abort_run();
		end
		// Only enabled byte lanes carry store data
		if (want_write && got_stb !== want_stb) begin
			$display("ERR dwstb: got %h, expected %h", got_stb, want_stb);
			abort_run();
		end
		if (want_write && (got_data & mask) !== (want_data & mask)) begin
			$display("ERR dwdata: got %h, expected %h", got_data & mask, want_data & mask);
			abort_run();
		end
	endtask

	function automatic logic [`EXEC_XLEN-1:0] mem_word(input logic [`EXEC_XLEN-1:0] addr);
		if (shadow_mem.exists(addr))
			return shadow_mem[addr];
		return {addr[15:0], addr[31:16]} ^ 32'h6c3a_e591;
	endfunction

	task automatic store_model(input logic [`EXEC_XLEN-1:0] addr,
			input logic [`EXEC_XLEN-1:0] data, input logic [3:0] stb);
		logic [`EXEC_XLEN-1:0] word;
		word = mem_word(addr);
		for (int i = 0; i < 4; i++) begin
			if (stb[i])
				word[8*i +: 8] = data[8*i +: 8];
		end
		shadow_mem[addr] = word;
	endtask

	function automatic logic [`EXEC_XLEN-1:0] load_model(input mem_op_e o,
			input logic [`EXEC_XLEN-1:0] word, input logic [1:0] lo);
		logic [7:0]  byte_val;
		logic [15:0] half_val;
		byte_val = word[8*lo +: 8];
		half_val = lo[1] ? word[31:16] : word[15:0];
		case (o)
			mem_lb:  return 32'($signed(byte_val));
			mem_lbu: return 32'(byte_val);
			mem_lh:  return 32'($signed(half_val));
			mem_lhu: return 32'(half_val);
			default: return word;
		endcase
	endfunction

	function automatic logic [`EXEC_XLEN-1:0] alu_model(input alu_op_e o,
			input logic [`EXEC_XLEN-1:0] a, input logic [`EXEC_XLEN-1:0] b);
		case (o)
			alu_add:        return a + b;
			alu_sub:        return a - b;
			alu_and:        return a & b;
			alu_or:         return a | b;
			alu_xor:        return a ^ b;
			alu_slt, alu_lt: return 32'($signed(a) < $signed(b));
			alu_ge:         return 32'($signed(a) >= $signed(b));
			alu_sltu:       return 32'(a < b);
			alu_eq:         return 32'(a == b);
			alu_ne:         return 32'(a != b);
			alu_pass_a:     return a;
			default:        return b;
		endcase
	endfunction

	function automatic logic [`EXEC_XLEN-1:0] mds_model(input mds_op_e o,
			input logic [`EXEC_XLEN-1:0] a, input logic [`EXEC_XLEN-1:0] b);
		case (o)
			mds_sll: return a << b[4:0];
			mds_srl: return a >> b[4:0];
			mds_sra: return $signed(a) >>> b[4:0];
			default: return a * b;
		endcase
	endfunction

	function automatic logic [`EXEC_XLEN-1:0] pc_step(input logic ic);
		return ic ? 32'd2 : 32'd4;
	endfunction

	// Acts as decoder and memory until instr_complete
	task automatic issue(input op_type_e t, input logic [3:0] o,
			input logic [`EXEC_XLEN-1:0] a, input logic [`EXEC_XLEN-1:0] b,
			input logic [`EXEC_XLEN-1:0] c, input logic [5:0] dest, input logic ic);
		logic bus_seen;
		logic bus_busy;
		int   wait_left;
		bus_seen = 1'b0;
		bus_busy = 1'b0;
		wait_left = 0;
		@(negedge clock);
		op_type = t;
		op = o;
		op_a = a;
		op_b = b;
		op_c = c;
		rd = dest;
		instr_c = ic;
		decode_valid = 1'b1;
		while (instr_complete !== 1'b1) begin
			dready = 1'b0;
			if (dvalid === 1'b1) begin
				if (!bus_busy) begin
					if (!bus_expected || bus_seen) begin
						$display("Data bus access that the instruction does not make");
						abort_run();
					end
					check_bus(daddr, dwrite, dwdata, dwstb,
						exp_daddr, exp_dwrite, exp_dwdata, exp_dwstb);
					bus_busy = 1'b1;
					bus_seen = 1'b1;
					wait_left = $urandom % 4;
				end
				if (wait_left == 0) begin
					dready = 1'b1;
					drdata = mem_word(daddr);
				end else begin
					wait_left--;
				end
			end else begin
				bus_busy = 1'b0;
			end
			#1;
			if (rd_wen === 1'b1) begin
				if (exp_waddr.size() == 0) begin
					$display("Register write that the instruction does not make");
					abort_run();
				end
				check_write(rd_waddr, rd_wdata, exp_waddr.pop_front(), exp_wdata.pop_front());
			end
			if (exec_unit_i.u_sva.fail_count != 0) begin
				$display("A bound assertion on the DUT failed");
				abort_run();
			end
			@(negedge clock);
		end
		decode_valid = 1'b0;
		if (exp_waddr.size() != 0) begin
			$display("Register write still missing at instr_complete");
			abort_run();
		end
		if (bus_expected && !bus_seen) begin
			$display("Data bus access still missing at instr_complete");
			abort_run();
		end
		bus_expected = 1'b0;
		check_pc(pc, pc_seq, model_pc, model_seq);
	endtask

	task automatic expect_trap(input logic [`EXEC_XLEN-1:0] tval, input logic [`EXEC_XLEN-1:0] cause);
		exp_waddr.push_back(`EXEC_CSR_MEPC);
		exp_wdata.push_back(model_pc);
		exp_waddr.push_back(`EXEC_CSR_MTVAL);
		exp_wdata.push_back(tval);
		exp_waddr.push_back(`EXEC_CSR_MCAUSE);
		exp_wdata.push_back(cause);
		model_pc = mtvec;
		model_seq = 1'b0;
	endtask

	task automatic arith_instr();
		alu_op_e               o;
		logic [`EXEC_XLEN-1:0] a;
		logic [`EXEC_XLEN-1:0] b;
		logic [5:0]            dest;
		logic                  ic;
		o = alu_op_e'(4'($urandom % 13));
		a = $urandom;
		b = ($urandom % 4 == 0) ? a : $urandom;
		dest = 6'($urandom % 32);
		ic = 1'($urandom);
		exp_waddr.push_back(dest);
		exp_wdata.push_back(alu_model(o, a, b));
		model_pc = model_pc + pc_step(ic);
		model_seq = 1'b1;
		issue(op_arith, o, a, b, $urandom, dest, ic);
	endtask

	task automatic branch_instr();
		alu_op_e               o;
		logic [`EXEC_XLEN-1:0] a;
		logic [`EXEC_XLEN-1:0] b;
		logic [`EXEC_XLEN-1:0] c;
		logic [`EXEC_XLEN-1:0] res;
		logic                  ic;
		case ($urandom % 5)
			0:       o = alu_eq;
			1:       o = alu_ne;
			2:       o = alu_lt;
			3:       o = alu_ge;
			default: o = alu_sltu;
		endcase
		a = $urandom;
		b = ($urandom % 3 == 0) ? a : $urandom;
		// Even offset, forward or backward
		c = ($urandom & 32'h0000_1ffe) - 32'h0000_1000;
		ic = 1'($urandom);
		res = alu_model(o, a, b);
		if (res[0]) begin
			model_pc = model_pc + c;
			model_seq = 1'b0;
		end else begin
			model_pc = model_pc + pc_step(ic);
			model_seq = 1'b1;
		end
		issue(op_branch, o, a, b, c, 6'($urandom % 32), ic);
	endtask

	task automatic jump_instr();
		logic [`EXEC_XLEN-1:0] a;
		logic [`EXEC_XLEN-1:0] c;
		logic [5:0]            dest;
		logic                  ic;
		a = $urandom;
		c = $urandom % 4096;
		dest = 6'($urandom % 32);
		ic = 1'($urandom);
		exp_waddr.push_back(dest);
		exp_wdata.push_back(model_pc + pc_step(ic));
		model_pc = (a + c) & ~32'h1;
		model_seq = 1'b0;
		issue(op_jump, 4'h0, a, $urandom, c, dest, ic);
	endtask

	task automatic mds_instr();
		mds_op_e               o;
		logic [`EXEC_XLEN-1:0] a;
		logic [`EXEC_XLEN-1:0] b;
		logic [5:0]            dest;
		logic                  ic;
		o = mds_op_e'(2'($urandom));
		a = $urandom;
		b = $urandom;
		dest = 6'($urandom % 32);
		ic = 1'($urandom);
		exp_waddr.push_back(dest);
		exp_wdata.push_back(mds_model(o, a, b));
		model_pc = model_pc + pc_step(ic);
		model_seq = 1'b1;
		issue(op_mds, {2'b00, o}, a, b, $urandom, dest, ic);
	endtask

	task automatic ldst_instr();
		mem_op_e               o;
		logic [1:0]            lo;
		logic [`EXEC_XLEN-1:0] addr;
		logic [`EXEC_XLEN-1:0] a;
		logic [`EXEC_XLEN-1:0] b;
		logic [5:0]            dest;
		logic                  ic;
		case ($urandom % 8)
			0:       o = mem_lb;
			1:       o = mem_lbu;
			2:       o = mem_lh;
			3:       o = mem_lhu;
			4:       o = mem_lw;
			5:       o = mem_sb;
			6:       o = mem_sh;
			default: o = mem_sw;
		endcase
		case (o)
			mem_lb, mem_lbu, mem_sb: lo = 2'($urandom);
			mem_lh, mem_lhu, mem_sh: lo = {1'($urandom), 1'b0};
			default:                 lo = 2'b00;
		endcase
		addr = LDST_BASE + (($urandom % 64) << 2) + 32'(lo);
		a = LDST_BASE + ($urandom % 256);
		b = $urandom;
		dest = 6'($urandom % 32);
		ic = 1'($urandom);
		bus_expected = 1'b1;
		exp_daddr = {addr[`EXEC_XLEN-1:2], 2'b00};
		exp_dwrite = o inside {mem_sb, mem_sh, mem_sw};
		if (exp_dwrite) begin
			case (o)
				mem_sb: begin
					exp_dwstb = 4'b0001 << lo;
					exp_dwdata = 32'(b[7:0]) << {lo, 3'b000};
				end
				mem_sh: begin
					exp_dwstb = 4'b0011 << lo;
					exp_dwdata = 32'(b[15:0]) << {lo, 3'b000};
				end
				default: begin
					exp_dwstb = 4'b1111;
					exp_dwdata = b;
				end
			endcase
			store_model(exp_daddr, exp_dwdata, exp_dwstb);
		end else begin
			exp_waddr.push_back(dest);
			exp_wdata.push_back(load_model(o, mem_word(exp_daddr), lo));
		end
		model_pc = model_pc + pc_step(ic);
		model_seq = 1'b1;
		issue(op_ldst, o, a, b, addr - a, dest, ic);
	endtask

	task automatic trap_instr();
		mem_op_e               o;
		logic [1:0]            lo;
		logic [`EXEC_XLEN-1:0] addr;
		logic [`EXEC_XLEN-1:0] a;
		logic                  ic;
		ic = 1'($urandom);
		case ($urandom % 4)
			0: begin
				case ($urandom % 5)
					0:       o = mem_lh;
					1:       o = mem_lhu;
					2:       o = mem_sh;
					3:       o = mem_lw;
					default: o = mem_sw;
				endcase
				lo = (o inside {mem_lh, mem_lhu, mem_sh}) ? {1'($urandom), 1'b1} :
					2'($urandom % 3 + 1);
				addr = LDST_BASE + (($urandom % 64) << 2) + 32'(lo);
				a = LDST_BASE + ($urandom % 256);
				expect_trap(addr, (o inside {mem_sh, mem_sw}) ? 32'd6 : 32'd4);
				issue(op_ldst, o, a, $urandom, addr - a, 6'($urandom % 32), ic);
			end
			1: begin
				expect_trap('0, 32'd11);
				issue(op_system, sys_ecall, $urandom, $urandom, $urandom, 6'd0, ic);
			end
			2: begin
				expect_trap('0, 32'd3);
				issue(op_system, sys_ebreak, $urandom, $urandom, $urandom, 6'd0, ic);
			end
			default: begin
				a = $urandom & ~32'h1;
				model_pc = a;
				model_seq = 1'b0;
				issue(op_system, sys_eret, a, $urandom, $urandom, 6'd0, ic);
			end
		endcase
	endtask

	// Cycle budget scales with the instruction count
	initial begin
		repeat (WATCH_CYCLES) @(posedge clock);
		$display("Timeout: the run did not finish within its cycle budget");
		abort_run();
	end

	initial begin
		void'($urandom(32'h946e));
		clock = 1'b0;
		reset = 1'b1;
		decode_valid = 1'b0;
		instr_c = 1'b0;
		op_type = op_arith;
		op = 4'h0;
		op_a = '0;
		op_b = '0;
		op_c = '0;
		rd = 6'd0;
		mtvec = 32'h8000_0000 | ($urandom & 32'h0000_fffc);
		drdata = '0;
		dready = 1'b0;
		bus_expected = 1'b0;
		repeat (10) @(negedge clock);
		reset = 1'b0;
		model_pc = `EXEC_RESET_PC;
		model_seq = 1'b1;
		check_pc(pc, pc_seq, model_pc, model_seq);
		for (int n = 0; n < NUM_INSTR; n++) begin
			case ($urandom % 7)
				0, 1:    arith_instr();
				2:       branch_instr();
				3:       jump_instr();
				4:       mds_instr();
				5:       ldst_instr();
				default: trap_instr();
			endcase
		end
		@(negedge clock);
		if (exec_unit_i.u_sva.fail_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1, "Run ended with failures");
		end
	end

endmodule

// File: src.f
+incdir+design
design/exec_pkg.sv
design/lsu_if.sv
design/exec_alu.sv
design/exec_mds.sv
design/exec_lsu.sv
design/exec_core.sv
design/exec_unit.sv
tb/exec_unit_sva.sv
tb/exec_unit_tb.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  - include_dirs:
      - design
    files:
      - design/exec_pkg.sv
      - design/lsu_if.sv
      - design/exec_alu.sv
      - design/exec_mds.sv
      - design/exec_lsu.sv
      - design/exec_core.sv
      - design/exec_unit.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/exec_unit_sva.sv
      - tb/exec_unit_tb.sv
